//--- verilog/tcdm_cfg_pkg.sv
// Scratchpad geometry constants, imported by every TCDM module that needs bank or width sizes
`default_nettype none

package tcdm_cfg_pkg;

    // ----------------------------------------
    // Port and bank counts
    // ----------------------------------------

    // One bank per narrow port
    localparam int unsigned NumNarrowBanks = 8;
    localparam int unsigned NumWideBanks   = 2;

    // Banks covered by one wide port
    // Must also equal WideDataWidth / NarrowDataWidth, checked in the arbiter
    localparam int unsigned NarrowPerWide  = NumNarrowBanks / NumWideBanks;

    // ----------------------------------------
    // Word widths and bank depth
    // ----------------------------------------

    localparam int unsigned NarrowDataWidth = 32;
    localparam int unsigned WideDataWidth   = 128;

    // Bank-local word address, 64 words per bank
    localparam int unsigned BankAddrWidth = 6;
    localparam int unsigned BankDepth     = 2 ** BankAddrWidth;

endpackage

`default_nettype wire

//--- verilog/tcdm_port_pkg.sv
// Port-level types of the scratchpad, shared by the request mux, the banks and the gatherer
`default_nettype none

package tcdm_port_pkg;

    import tcdm_cfg_pkg::*;

    // One bank word
    typedef logic [NarrowDataWidth-1:0] narrow_word_t;

    // Word address inside one bank
    typedef logic [BankAddrWidth-1:0] bank_addr_t;

    // ----------------------------------------
    // Wide word, two views
    // ----------------------------------------

    // Lane k maps to bank group * NarrowPerWide + k, lane 0 in the low bits
    typedef union packed {
        logic [WideDataWidth-1:0]              flat;
        narrow_word_t [NarrowPerWide-1:0]      lane;
    } wide_word_u;

    // ----------------------------------------
    // Owner tag carried with each bank access
    // ----------------------------------------

    localparam logic OwnerNarrow = 1'b0;
    localparam logic OwnerWide   = 1'b1;

endpackage

`default_nettype wire

//--- verilog/wide_narrow_arbiter.sv
// Alternating narrow/wide priority that drives the ready strobes of all scratchpad ports
`default_nettype none

module wide_narrow_arbiter (
    input  logic                                    clk_i,
    input  logic                                    rst_ni,

    // Narrow ports
    input  logic [tcdm_cfg_pkg::NumNarrowBanks-1:0] narrow_valid_i,
    output logic [tcdm_cfg_pkg::NumNarrowBanks-1:0] narrow_ready_o,

    // Wide ports
    input  logic [tcdm_cfg_pkg::NumWideBanks-1:0]   wide_valid_i,
    output logic [tcdm_cfg_pkg::NumWideBanks-1:0]   wide_ready_o
);

    import tcdm_cfg_pkg::*;

    // High when narrow traffic wins this cycle
    logic prio_narrow_q;

    // Narrow valids merged per group
    logic [NumWideBanks-1:0]   narrow_any;
    // Wide valid spread over its banks
    logic [NumNarrowBanks-1:0] wide_fanout;

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            prio_narrow_q <= 1'b1;
        end else begin
            prio_narrow_q <= ~prio_narrow_q;
        end
    end

    for (genvar g = 0; g < NumWideBanks; g++) begin : gen_group
        assign narrow_any[g] = |narrow_valid_i[g*NarrowPerWide +: NarrowPerWide];
    end

    for (genvar i = 0; i < NumNarrowBanks; i++) begin : gen_fanout
        assign wide_fanout[i] = wide_valid_i[i / NarrowPerWide];
    end

    // ----------------------------------------
    // Ready rule
    // ----------------------------------------

    always_comb begin
        if (prio_narrow_q) begin
            // Narrow first, a wide port yields to any narrow valid in its group
            narrow_ready_o = '1;
            wide_ready_o   = ~narrow_any;
        end else begin
            wide_ready_o   = '1;
            narrow_ready_o = ~wide_fanout;
        end
    end

    // ----------------------------------------
    // Assertions
    // ----------------------------------------

    // Bank groups must tile the banks and match the wide word exactly
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        (NarrowPerWide * NumWideBanks == NumNarrowBanks) &&
        (NarrowPerWide == WideDataWidth / NarrowDataWidth) &&
        (WideDataWidth % NarrowDataWidth == 0))
        else $error("Bank geometry does not match the wide/narrow widths");

    // Priority alternates so each side sees all its readies high every other cycle
    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(&narrow_ready_o) |=> (&narrow_ready_o))
        else $error("Narrow side missed its priority cycle");

    assert property (@(posedge clk_i) disable iff (!rst_ni)
        !(&wide_ready_o) |=> (&wide_ready_o))
        else $error("Wide side missed its priority cycle");

endmodule

`default_nettype wire

//--- verilog/bank_request_mux.sv
// Per-bank selection of the granted narrow request or the owning wide port's lane
`default_nettype none

module bank_request_mux (
    // Only used by the grant check
    input  logic                                               clk_i,
    input  logic                                               rst_ni,

    // Narrow requests
    input  logic [tcdm_cfg_pkg::NumNarrowBanks-1:0]            narrow_valid_i,
    input  logic [tcdm_cfg_pkg::NumNarrowBanks-1:0]            narrow_ready_i,
    input  logic [tcdm_cfg_pkg::NumNarrowBanks-1:0]            narrow_we_i,
    input  tcdm_port_pkg::bank_addr_t [tcdm_cfg_pkg::NumNarrowBanks-1:0]   narrow_addr_i,
    input  tcdm_port_pkg::narrow_word_t [tcdm_cfg_pkg::NumNarrowBanks-1:0] narrow_wdata_i,

    // Wide requests
    input  logic [tcdm_cfg_pkg::NumWideBanks-1:0]              wide_valid_i,
    input  logic [tcdm_cfg_pkg::NumWideBanks-1:0]              wide_ready_i,
    input  logic [tcdm_cfg_pkg::NumWideBanks-1:0]              wide_we_i,
    input  tcdm_port_pkg::bank_addr_t [tcdm_cfg_pkg::NumWideBanks-1:0]     wide_addr_i,
    input  logic [tcdm_cfg_pkg::NumWideBanks-1:0][tcdm_cfg_pkg::WideDataWidth-1:0] wide_wdata_i,

    // Bank requests
    output logic [tcdm_cfg_pkg::NumNarrowBanks-1:0]            bank_req_o,
    output logic [tcdm_cfg_pkg::NumNarrowBanks-1:0]            bank_we_o,
    output tcdm_port_pkg::bank_addr_t [tcdm_cfg_pkg::NumNarrowBanks-1:0]   bank_addr_o,
    output tcdm_port_pkg::narrow_word_t [tcdm_cfg_pkg::NumNarrowBanks-1:0] bank_wdata_o,
    output logic [tcdm_cfg_pkg::NumNarrowBanks-1:0]            bank_wide_o
);

    import tcdm_cfg_pkg::*;
    import tcdm_port_pkg::*;

    logic [NumNarrowBanks-1:0] narrow_gnt;
    logic [NumWideBanks-1:0]   wide_gnt;

    assign narrow_gnt = narrow_valid_i & narrow_ready_i;
    assign wide_gnt   = wide_valid_i & wide_ready_i;

    for (genvar g = 0; g < NumWideBanks; g++) begin : gen_group
        // Wide write data split into bank lanes
        wide_word_u wdata_u;

        assign wdata_u.flat = wide_wdata_i[g];

        for (genvar k = 0; k < NarrowPerWide; k++) begin : gen_lane
            localparam int unsigned Bank = g * NarrowPerWide + k;

            // Narrow grant takes the bank, else the wide lane
            assign bank_req_o[Bank]   = narrow_gnt[Bank] | wide_gnt[g];
            assign bank_we_o[Bank]    = narrow_gnt[Bank] ? narrow_we_i[Bank] : wide_we_i[g];
            assign bank_addr_o[Bank]  = narrow_gnt[Bank] ? narrow_addr_i[Bank] : wide_addr_i[g];
            assign bank_wdata_o[Bank] = narrow_gnt[Bank] ? narrow_wdata_i[Bank] : wdata_u.lane[k];
            assign bank_wide_o[Bank]  = narrow_gnt[Bank] ? OwnerNarrow : OwnerWide;

            // The arbiter must never hand one bank to both sides
            assert property (@(posedge clk_i) disable iff (!rst_ni)
                !(narrow_gnt[Bank] && wide_gnt[g]))
                else $error("Bank %0d granted to narrow and wide at once", Bank);
        end
    end

endmodule

`default_nettype wire

//--- verilog/sram_bank.sv
// One single-port scratchpad bank with one-cycle read latency and an echoed owner tag
`default_nettype none

module sram_bank (
    input  logic                       clk_i,
    input  logic                       rst_ni,

    // Request
    input  logic                       req_i,
    input  logic                       we_i,
    input  tcdm_port_pkg::bank_addr_t  addr_i,
    input  tcdm_port_pkg::narrow_word_t wdata_i,
    input  logic                       wide_i,

    // Read response, one cycle after the request
    output logic                       rvalid_o,
    output tcdm_port_pkg::narrow_word_t rdata_o,
    output logic                       rwide_o
);

    import tcdm_cfg_pkg::*;
    import tcdm_port_pkg::*;

    narrow_word_t mem_q [BankDepth];
    narrow_word_t rdata_q;
    logic         rvalid_q;
    logic         rwide_q;

    // Storage and read data path
    always_ff @(posedge clk_i) begin
        if (req_i && we_i) begin
            mem_q[addr_i] <= wdata_i;
        end
        if (req_i && !we_i) begin
            rdata_q <= mem_q[addr_i];
            rwide_q <= wide_i;
        end
    end

    always_ff @(posedge clk_i or negedge rst_ni) begin
        if (!rst_ni) begin
            rvalid_q <= 1'b0;
        end else begin
            rvalid_q <= req_i && !we_i;
        end
    end

    assign rvalid_o = rvalid_q;
    assign rdata_o  = rdata_q;
    assign rwide_o  = rwide_q;

endmodule

`default_nettype wire

//--- verilog/response_gather.sv
// Routes bank read data to the narrow ports or assembles it into wide read words
`default_nettype none

module response_gather (
    // Only used by the lane check
    input  logic                                               clk_i,
    input  logic                                               rst_ni,

    // Bank responses
    input  logic [tcdm_cfg_pkg::NumNarrowBanks-1:0]            bank_rvalid_i,
    input  tcdm_port_pkg::narrow_word_t [tcdm_cfg_pkg::NumNarrowBanks-1:0] bank_rdata_i,
    input  logic [tcdm_cfg_pkg::NumNarrowBanks-1:0]            bank_rwide_i,

    // Narrow responses
    output logic [tcdm_cfg_pkg::NumNarrowBanks-1:0]            narrow_rvalid_o,
    output tcdm_port_pkg::narrow_word_t [tcdm_cfg_pkg::NumNarrowBanks-1:0] narrow_rdata_o,

    // Wide responses
    output logic [tcdm_cfg_pkg::NumWideBanks-1:0]              wide_rvalid_o,
    output logic [tcdm_cfg_pkg::NumWideBanks-1:0][tcdm_cfg_pkg::WideDataWidth-1:0] wide_rdata_o
);

    import tcdm_cfg_pkg::*;
    import tcdm_port_pkg::*;

    // Narrow side passes data straight through, valid only for narrow-owned reads
    always_comb begin
        for (int unsigned i = 0; i < NumNarrowBanks; i++) begin
            narrow_rvalid_o[i] = bank_rvalid_i[i] && (bank_rwide_i[i] == OwnerNarrow);
            narrow_rdata_o[i]  = bank_rdata_i[i];
        end
    end

    for (genvar g = 0; g < NumWideBanks; g++) begin : gen_group
        wide_word_u               rdata_u;
        logic [NarrowPerWide-1:0] lane_wide;

        // Merge the group's lanes into one wide word
        always_comb begin
            for (int unsigned k = 0; k < NarrowPerWide; k++) begin
                rdata_u.lane[k] = bank_rdata_i[g*NarrowPerWide + k];
                lane_wide[k]    = bank_rvalid_i[g*NarrowPerWide + k] &&
                                  (bank_rwide_i[g*NarrowPerWide + k] == OwnerWide);
            end
        end

        assign wide_rvalid_o[g] = &lane_wide;
        assign wide_rdata_o[g]  = rdata_u.flat;

        // A wide read hits all banks of its group in the same cycle
        assert property (@(posedge clk_i) disable iff (!rst_ni)
            (lane_wide == '0) || (lane_wide == '1))
            else $error("Wide group %0d returned a partial set of lanes", g);
    end

endmodule

`default_nettype wire

//--- verilog/tcdm_subsystem.sv
// Top level of the banked scratchpad, connecting arbiter, request mux, banks and gatherer
`default_nettype none

module tcdm_subsystem (
    input  logic                                               clk_i,
    input  logic                                               rst_ni,

    // Narrow ports, one per bank
    input  logic [tcdm_cfg_pkg::NumNarrowBanks-1:0]            narrow_valid_i,
    input  logic [tcdm_cfg_pkg::NumNarrowBanks-1:0]            narrow_we_i,
    input  tcdm_port_pkg::bank_addr_t [tcdm_cfg_pkg::NumNarrowBanks-1:0]   narrow_addr_i,
    input  tcdm_port_pkg::narrow_word_t [tcdm_cfg_pkg::NumNarrowBanks-1:0] narrow_wdata_i,
    output logic [tcdm_cfg_pkg::NumNarrowBanks-1:0]            narrow_ready_o,
    output logic [tcdm_cfg_pkg::NumNarrowBanks-1:0]            narrow_rvalid_o,
    output tcdm_port_pkg::narrow_word_t [tcdm_cfg_pkg::NumNarrowBanks-1:0] narrow_rdata_o,

    // Wide ports, one per bank group
    input  logic [tcdm_cfg_pkg::NumWideBanks-1:0]              wide_valid_i,
    input  logic [tcdm_cfg_pkg::NumWideBanks-1:0]              wide_we_i,
    input  tcdm_port_pkg::bank_addr_t [tcdm_cfg_pkg::NumWideBanks-1:0]     wide_addr_i,
    input  logic [tcdm_cfg_pkg::NumWideBanks-1:0][tcdm_cfg_pkg::WideDataWidth-1:0] wide_wdata_i,
    output logic [tcdm_cfg_pkg::NumWideBanks-1:0]              wide_ready_o,
    output logic [tcdm_cfg_pkg::NumWideBanks-1:0]              wide_rvalid_o,
    output logic [tcdm_cfg_pkg::NumWideBanks-1:0][tcdm_cfg_pkg::WideDataWidth-1:0] wide_rdata_o
);

    import tcdm_cfg_pkg::*;
    import tcdm_port_pkg::*;

    // Mux to banks
    logic [NumNarrowBanks-1:0]         bank_req;
    logic [NumNarrowBanks-1:0]         bank_we;
    bank_addr_t [NumNarrowBanks-1:0]   bank_addr;
    narrow_word_t [NumNarrowBanks-1:0] bank_wdata;
    logic [NumNarrowBanks-1:0]         bank_wide;

    // Banks to gatherer
    logic [NumNarrowBanks-1:0]         bank_rvalid;
    narrow_word_t [NumNarrowBanks-1:0] bank_rdata;
    logic [NumNarrowBanks-1:0]         bank_rwide;

    wide_narrow_arbiter wide_narrow_arbiter_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .narrow_valid_i (narrow_valid_i),
        .narrow_ready_o (narrow_ready_o),
        .wide_valid_i   (wide_valid_i),
        .wide_ready_o   (wide_ready_o)
    );

    bank_request_mux bank_request_mux_inst (
        .clk_i          (clk_i),
        .rst_ni         (rst_ni),
        .narrow_valid_i (narrow_valid_i),
        .narrow_ready_i (narrow_ready_o),
        .narrow_we_i    (narrow_we_i),
        .narrow_addr_i  (narrow_addr_i),
        .narrow_wdata_i (narrow_wdata_i),
        .wide_valid_i   (wide_valid_i),
        .wide_ready_i   (wide_ready_o),
        .wide_we_i      (wide_we_i),
        .wide_addr_i    (wide_addr_i),
        .wide_wdata_i   (wide_wdata_i),
        .bank_req_o     (bank_req),
        .bank_we_o      (bank_we),
        .bank_addr_o    (bank_addr),
        .bank_wdata_o   (bank_wdata),
        .bank_wide_o    (bank_wide)
    );

    for (genvar b = 0; b < NumNarrowBanks; b++) begin : gen_bank
        sram_bank sram_bank_inst (
            .clk_i    (clk_i),
            .rst_ni   (rst_ni),
            .req_i    (bank_req[b]),
            .we_i     (bank_we[b]),
            .addr_i   (bank_addr[b]),
            .wdata_i  (bank_wdata[b]),
            .wide_i   (bank_wide[b]),
            .rvalid_o (bank_rvalid[b]),
            .rdata_o  (bank_rdata[b]),
            .rwide_o  (bank_rwide[b])
        );
    end

    response_gather response_gather_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .bank_rvalid_i   (bank_rvalid),
        .bank_rdata_i    (bank_rdata),
        .bank_rwide_i    (bank_rwide),
        .narrow_rvalid_o (narrow_rvalid_o),
        .narrow_rdata_o  (narrow_rdata_o),
        .wide_rvalid_o   (wide_rvalid_o),
        .wide_rdata_o    (wide_rdata_o)
    );

endmodule

`default_nettype wire

//--- dv/tb_tcdm_subsystem.sv
// Random-traffic testbench for the scratchpad, checks ready, read data and grant latency
`default_nettype none

module tb_tcdm_subsystem;

    timeunit 1ns;
    timeprecision 1ps;

    import tcdm_cfg_pkg::*;
    import tcdm_port_pkg::*;

    localparam int unsigned NumCycles = 2000;
    // Small address window so that ports keep hitting the same words
    localparam int unsigned AddrRange = 8;

    logic clk_i;
    logic rst_ni;

    // DUT narrow side
    logic [NumNarrowBanks-1:0]               narrow_valid;
    logic [NumNarrowBanks-1:0]               narrow_we;
    bank_addr_t [NumNarrowBanks-1:0]         narrow_addr;
    narrow_word_t [NumNarrowBanks-1:0]       narrow_wdata;
    logic [NumNarrowBanks-1:0]               narrow_ready;
    logic [NumNarrowBanks-1:0]               narrow_rvalid;
    narrow_word_t [NumNarrowBanks-1:0]       narrow_rdata;

    // DUT wide side
    logic [NumWideBanks-1:0]                 wide_valid;
    logic [NumWideBanks-1:0]                 wide_we;
    bank_addr_t [NumWideBanks-1:0]           wide_addr;
    logic [NumWideBanks-1:0][WideDataWidth-1:0] wide_wdata;
    logic [NumWideBanks-1:0]                 wide_ready;
    logic [NumWideBanks-1:0]                 wide_rvalid;
    logic [NumWideBanks-1:0][WideDataWidth-1:0] wide_rdata;

    // ----------------------------------------
    // Model state
    // ----------------------------------------

    narrow_word_t model_mem [NumNarrowBanks][BankDepth];
    logic         prio_narrow;

    // Read responses expected in the current cycle
    logic [NumNarrowBanks-1:0]                  n_exp_valid;
    narrow_word_t [NumNarrowBanks-1:0]          n_exp_data;
    logic [NumWideBanks-1:0]                    w_exp_valid;
    logic [NumWideBanks-1:0][WideDataWidth-1:0] w_exp_data;

    // Requests accepted on the coming edge
    logic [NumNarrowBanks-1:0] n_taken;
    logic [NumWideBanks-1:0]   w_taken;

    int unsigned narrow_wait [NumNarrowBanks];
    int unsigned wide_wait [NumWideBanks];
    int unsigned preload_cnt [NumNarrowBanks];
    bit          preload_done;
    int unsigned err_cnt;
    int unsigned check_cnt;

    tcdm_subsystem tcdm_subsystem_inst (
        .clk_i           (clk_i),
        .rst_ni          (rst_ni),
        .narrow_valid_i  (narrow_valid),
        .narrow_we_i     (narrow_we),
        .narrow_addr_i   (narrow_addr),
        .narrow_wdata_i  (narrow_wdata),
        .narrow_ready_o  (narrow_ready),
        .narrow_rvalid_o (narrow_rvalid),
        .narrow_rdata_o  (narrow_rdata),
        .wide_valid_i    (wide_valid),
        .wide_we_i       (wide_we),
        .wide_addr_i     (wide_addr),
        .wide_wdata_i    (wide_wdata),
        .wide_ready_o    (wide_ready),
        .wide_rvalid_o   (wide_rvalid),
        .wide_rdata_o    (wide_rdata)
    );

    initial begin
        clk_i = 1'b0;
        forever #5 clk_i = ~clk_i;
    end

    task automatic report_error(input string msg);
        err_cnt++;
        $display("** Error at time %0t: %s", $time, msg);
    endtask

    // ----------------------------------------
    // Stimulus, driven just after the edge
    // ----------------------------------------

    task automatic new_requests();
        bit all_loaded;
        all_loaded = 1'b1;
        narrow_valid = narrow_valid & ~n_taken;
        wide_valid   = wide_valid & ~w_taken;
        foreach (preload_cnt[i]) begin
            if (preload_cnt[i] < AddrRange) begin
                all_loaded = 1'b0;
            end
        end
        // Wide traffic waits until every word in the window holds data
        if (all_loaded && narrow_valid == '0) begin
            preload_done = 1'b1;
        end
        for (int unsigned i = 0; i < NumNarrowBanks; i++) begin
            if (!narrow_valid[i] && preload_cnt[i] < AddrRange) begin
                narrow_valid[i] = 1'b1;
                narrow_we[i]    = 1'b1;
                narrow_addr[i]  = bank_addr_t'(preload_cnt[i]);
                narrow_wdata[i] = $urandom();
                preload_cnt[i]++;
            end else if (!narrow_valid[i] && $urandom_range(0, 9) < 5) begin
                narrow_valid[i] = 1'b1;
                narrow_we[i]    = ($urandom_range(0, 1) == 1);
                narrow_addr[i]  = bank_addr_t'($urandom_range(0, AddrRange - 1));
                narrow_wdata[i] = $urandom();
            end
        end
        for (int unsigned g = 0; g < NumWideBanks; g++) begin
            if (preload_done && !wide_valid[g] && $urandom_range(0, 9) < 3) begin
                wide_valid[g] = 1'b1;
                wide_we[g]    = ($urandom_range(0, 1) == 1);
                wide_addr[g]  = bank_addr_t'($urandom_range(0, AddrRange - 1));
                wide_wdata[g] = {$urandom(), $urandom(), $urandom(), $urandom()};
            end
        end
    endtask

    // ----------------------------------------
    // Checks and model update, mid-cycle
    // ----------------------------------------

    task automatic check_cycle(input bit first_cycle);
        logic [NumWideBanks-1:0]   group_busy;
        logic [NumNarrowBanks-1:0] exp_nready;
        logic [NumWideBanks-1:0]   exp_wready;
        logic [WideDataWidth-1:0]  word;
        int unsigned               bank;

        // Responses to the reads granted one cycle ago
        for (int unsigned i = 0; i < NumNarrowBanks; i++) begin
            check_cnt++;
            if (narrow_rvalid[i] !== n_exp_valid[i]) begin
                report_error($sformatf("narrow_rvalid[%0d] is %b, expected %b",
                                       i, narrow_rvalid[i], n_exp_valid[i]));
            end else if (n_exp_valid[i] && narrow_rdata[i] !== n_exp_data[i]) begin
                report_error($sformatf("narrow_rdata[%0d] is %h, expected %h",
                                       i, narrow_rdata[i], n_exp_data[i]));
            end
        end
        for (int unsigned g = 0; g < NumWideBanks; g++) begin
            check_cnt++;
            if (wide_rvalid[g] !== w_exp_valid[g]) begin
                report_error($sformatf("wide_rvalid[%0d] is %b, expected %b",
                                       g, wide_rvalid[g], w_exp_valid[g]));
            end else if (w_exp_valid[g] && wide_rdata[g] !== w_exp_data[g]) begin
                report_error($sformatf("wide_rdata[%0d] is %h, expected %h",
                                       g, wide_rdata[g], w_exp_data[g]));
            end
        end

        // Ready from the alternating priority
        for (int unsigned g = 0; g < NumWideBanks; g++) begin
            group_busy[g] = |narrow_valid[g*NarrowPerWide +: NarrowPerWide];
            exp_wready[g] = prio_narrow ? ~group_busy[g] : 1'b1;
        end
        for (int unsigned i = 0; i < NumNarrowBanks; i++) begin
            exp_nready[i] = prio_narrow ? 1'b1 : ~wide_valid[i / NarrowPerWide];
        end
        check_cnt++;
        if (narrow_ready !== exp_nready || wide_ready !== exp_wready) begin
            report_error($sformatf("ready is narrow %b wide %b, expected narrow %b wide %b",
                                   narrow_ready, wide_ready, exp_nready, exp_wready));
        end
        if (first_cycle && narrow_ready !== '1) begin
            report_error($sformatf("narrow_ready is %b in the first cycle after reset",
                                   narrow_ready));
        end

        // Grants as the DUT hands them out on the coming edge
        n_taken     = narrow_valid & narrow_ready;
        w_taken     = wide_valid & wide_ready;
        n_exp_valid = '0;
        w_exp_valid = '0;

        for (int unsigned i = 0; i < NumNarrowBanks; i++) begin
            if (n_taken[i]) begin
                narrow_wait[i] = 0;
                if (narrow_we[i]) begin
                    model_mem[i][narrow_addr[i]] = narrow_wdata[i];
                end else begin
                    n_exp_valid[i] = 1'b1;
                    n_exp_data[i]  = model_mem[i][narrow_addr[i]];
                end
            end else if (narrow_valid[i]) begin
                narrow_wait[i]++;
                if (narrow_wait[i] >= 2) begin
                    err_cnt++;
                    $display("Narrow port %0d was not granted within two cycles at time %0t",
                             i, $time);
                    narrow_wait[i] = 0;
                end
            end
        end

        for (int unsigned g = 0; g < NumWideBanks; g++) begin
            if (w_taken[g]) begin
                wide_wait[g] = 0;
                // Lane k belongs to bank g * NarrowPerWide + k
                for (int unsigned k = 0; k < NarrowPerWide; k++) begin
                    bank = g * NarrowPerWide + k;
                    if (wide_we[g]) begin
                        model_mem[bank][wide_addr[g]] =
                            wide_wdata[g][k*NarrowDataWidth +: NarrowDataWidth];
                    end else begin
                        word[k*NarrowDataWidth +: NarrowDataWidth] = model_mem[bank][wide_addr[g]];
                    end
                end
                if (!wide_we[g]) begin
                    w_exp_valid[g] = 1'b1;
                    w_exp_data[g]  = word;
                end
            end else if (wide_valid[g]) begin
                wide_wait[g]++;
                if (wide_wait[g] >= 2) begin
                    err_cnt++;
                    $display("Wide port %0d was not granted within two cycles at time %0t",
                             g, $time);
                    wide_wait[g] = 0;
                end
            end
        end
    endtask

    // ----------------------------------------
    // Main sequence
    // ----------------------------------------

    initial begin
        void'($urandom(32'h642d));
        rst_ni       = 1'b0;
        narrow_valid = '0;
        narrow_we    = '0;
        narrow_addr  = '0;
        narrow_wdata = '0;
        wide_valid   = '0;
        wide_we      = '0;
        wide_addr    = '0;
        wide_wdata   = '0;
        n_exp_valid  = '0;
        n_exp_data   = '0;
        w_exp_valid  = '0;
        w_exp_data   = '0;
        n_taken      = '0;
        w_taken      = '0;
        preload_done = 1'b0;
        prio_narrow  = 1'b1;
        err_cnt      = 0;
        check_cnt    = 0;
        foreach (narrow_wait[i]) begin
            narrow_wait[i] = 0;
            preload_cnt[i] = 0;
        end
        foreach (wide_wait[g]) begin
            wide_wait[g] = 0;
        end

        // Reset held for three cycles, responses must stay quiet
        repeat (2) @(posedge clk_i);
        @(negedge clk_i);
        check_cnt++;
        if (narrow_rvalid !== '0 || wide_rvalid !== '0) begin
            report_error($sformatf("rvalid high in reset, narrow %b wide %b",
                                   narrow_rvalid, wide_rvalid));
        end
        @(posedge clk_i);
        #1;
        rst_ni = 1'b1;

        for (int unsigned cyc = 0; cyc < NumCycles; cyc++) begin
            new_requests();
            @(negedge clk_i);
            check_cycle(cyc == 0);
            @(posedge clk_i);
            prio_narrow = ~prio_narrow;
            #1;
        end

        $display("Summary: %0d checks, %0d errors", check_cnt, err_cnt);
        if (err_cnt == 0) begin
            $display("TESTS PASSED");
        end else begin
            $display("TESTS FAILED");
        end
        $finish;
    end

endmodule

`default_nettype wire

//--- vlog.f
verilog/tcdm_cfg_pkg.sv
verilog/tcdm_port_pkg.sv
verilog/wide_narrow_arbiter.sv
verilog/bank_request_mux.sv
verilog/sram_bank.sv
verilog/response_gather.sv
verilog/tcdm_subsystem.sv
dv/tb_tcdm_subsystem.sv

//--- Makefile
VERILATOR := verilator
VFLAGS    := --binary --timing --assert -j 0
TOP       := tb_tcdm_subsystem
FILELIST  := vlog.f
OBJ_DIR   := obj_dir
PASS_MSG  := TESTS PASSED

.PHONY: help test clean

help:
	@echo "Targets:"
	@echo "  test   build with Verilator and run the testbench"
	@echo "  clean  remove the build directory"
	@echo "  help   show this list"

test:
	$(VERILATOR) $(VFLAGS) --top-module $(TOP) -f $(FILELIST) --Mdir $(OBJ_DIR)
	@out="$$(./$(OBJ_DIR)/V$(TOP))"; \
	echo "$$out"; \
	echo "$$out" | grep -qx "$(PASS_MSG)"

clean:
	rm -rf $(OBJ_DIR)
